// ==== include/gl_cfg.svh ====
`ifndef GL_CFG_SVH
`define GL_CFG_SVH

////////////////////
// Command memory
////////////////////

// Depth in 32-bit words, keep it a power of two
`define GL_MEM_WORDS 256

// Byte address width covering the whole memory
`define GL_ADDR_W ($clog2(`GL_MEM_WORDS) + 2)

////////////////////
// Fetch
////////////////////

// Byte address of the first opcode word
`define GL_TEXT_START 0

`endif

// ==== rtl/gl_pkg.sv ====
`include "gl_cfg.svh"

package gl_pkg;

    ////////////////////
    // Basic types
    ////////////////////

    // One command or operand word
    typedef logic [31:0] word_t;

    // Byte address into the command memory, always word aligned
    typedef logic [`GL_ADDR_W-1:0] byte_addr_t;

    // Opcode lives in the low byte of a command word
    typedef logic [7:0] opcode_t;

    // Operand index, wide enough to also hold a count of 16
    typedef logic [4:0] operand_idx_t;

    ////////////////////
    // Opcodes
    ////////////////////

    // End of stream, halts fetch
    localparam opcode_t OP_END        = 8'h00;
    localparam opcode_t OP_VERTEX     = 8'h03;
    localparam opcode_t OP_COLOR      = 8'h04;
    localparam opcode_t OP_MULTMATRIX = 8'h11;
    localparam opcode_t OP_LOADMATRIX = 8'h13;
    localparam opcode_t OP_ROTATE     = 8'h16;
    localparam opcode_t OP_SCALE      = 8'h17;
    localparam opcode_t OP_TRANSLATE  = 8'h18;
    localparam opcode_t OP_VIEWPORT   = 8'h19;
    localparam opcode_t OP_FRUSTUM    = 8'h1A;

    // Number of operand words following an opcode
    // Unknown opcodes and END have none
    function automatic operand_idx_t operand_count(input opcode_t op);
        case (op)
            OP_VERTEX,
            OP_COLOR:
                operand_count = 5'd3;
            OP_MULTMATRIX,
            OP_LOADMATRIX,
            OP_ROTATE,
            OP_SCALE,
            OP_TRANSLATE:
                operand_count = 5'd16;
            OP_VIEWPORT:
                operand_count = 5'd4;
            OP_FRUSTUM:
                operand_count = 5'd6;
            default:
                operand_count = 5'd0;
        endcase
    endfunction

    ////////////////////
    // State machines
    ////////////////////

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_ISSUE,
        FETCH_DECODE,
        FETCH_WAIT,
        FETCH_HALT
    } fetch_state_t;

    typedef enum logic {
        READ_IDLE,
        READ_BURST
    } reader_state_t;

endpackage

// ==== rtl/gl_cmd_mem.sv ====
`timescale 1ns/1ps
`include "gl_cfg.svh"

module gl_cmd_mem (
    input  logic               clk,
    input  logic               load_en,
    input  gl_pkg::byte_addr_t load_addr,
    input  gl_pkg::word_t      load_data,
    input  gl_pkg::byte_addr_t inst_addr,
    output gl_pkg::word_t      inst_data,
    input  gl_pkg::byte_addr_t operand_addr,
    output gl_pkg::word_t      operand_rdata
);
    import gl_pkg::*;

    word_t mem [`GL_MEM_WORDS];

    // Load port, word index is the byte address over four
    always_ff @(posedge clk)
    begin
        if (load_en)
            mem[load_addr[`GL_ADDR_W-1:2]] <= load_data;
    end

    // Two registered read ports, one for opcodes and one for operands
    always_ff @(posedge clk)
    begin
        inst_data     <= mem[inst_addr[`GL_ADDR_W-1:2]];
        operand_rdata <= mem[operand_addr[`GL_ADDR_W-1:2]];
    end

    // Fetch and reader only ever present word aligned addresses
    a_read_aligned : assert property (
        @(posedge clk) (inst_addr[1:0] == 2'b00) && (operand_addr[1:0] == 2'b00)
    ) else $error("gl_cmd_mem: unaligned read address");

    // The loader writes whole words only
    a_load_aligned : assert property (
        @(posedge clk) load_en |-> (load_addr[1:0] == 2'b00)
    ) else $error("gl_cmd_mem: unaligned load address %h", load_addr);

endmodule

// ==== rtl/gl_fetch.sv ====
`timescale 1ns/1ps
`include "gl_cfg.svh"

module gl_fetch (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 hold,
    output gl_pkg::byte_addr_t   inst_addr,
    input  gl_pkg::word_t        inst_data,
    output logic                 cmd_valid,
    output gl_pkg::opcode_t      cmd_opcode,
    output logic                 launch,
    output gl_pkg::opcode_t      launch_opcode,
    output gl_pkg::byte_addr_t   launch_base,
    input  logic                 burst_done,
    output logic                 done
);
    import gl_pkg::*;

    localparam int WORD_W = `GL_ADDR_W - 2;
    localparam byte_addr_t TEXT_START = byte_addr_t'(`GL_TEXT_START);
    localparam logic [WORD_W-1:0] START_WORD = TEXT_START[`GL_ADDR_W-1:2];

    fetch_state_t state;

    // Program counter held as a word index
    logic [WORD_W-1:0] pc_word;
    logic [WORD_W-1:0] next_word;

    opcode_t      dec_opcode;
    operand_idx_t dec_count;

    assign inst_addr = {pc_word, 2'b00};

    // Decode of the word returned for the current pc
    always_comb
    begin
        dec_opcode = inst_data[7:0];
        dec_count  = operand_count(dec_opcode);
        next_word  = pc_word + 1'b1;
    end

    ////////////////////
    // State machine
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state     <= FETCH_IDLE;
            pc_word   <= START_WORD;
            cmd_valid <= 1'b0;
            launch    <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            launch    <= 1'b0;
            case (state)
                FETCH_IDLE:
                begin
                    if (start)
                    begin
                        pc_word <= START_WORD;
                        state   <= FETCH_ISSUE;
                    end
                end
                FETCH_ISSUE:
                begin
                    // Memory read of pc completes here
                    // Hold keeps the state parked
                    if (!hold)
                        state <= FETCH_DECODE;
                end
                FETCH_DECODE:
                begin
                    if (dec_opcode == OP_END)
                    begin
                        done  <= 1'b1;
                        state <= FETCH_HALT;
                    end
                    else
                    begin
                        cmd_valid <= 1'b1;
                        // Skip opcode word plus all operand words
                        pc_word   <= pc_word + WORD_W'(dec_count) + 1'b1;
                        if (dec_count != 5'd0)
                        begin
                            launch <= 1'b1;
                            state  <= FETCH_WAIT;
                        end
                        else
                            state <= FETCH_ISSUE;
                    end
                end
                FETCH_WAIT:
                begin
                    if (burst_done)
                        state <= FETCH_ISSUE;
                end
                FETCH_HALT:
                begin
                    // Stays here until reset
                    state <= FETCH_HALT;
                end
                default:
                    state <= FETCH_IDLE;
            endcase
        end
    end

    // Command payload qualified by the strobes above
    always_ff @(posedge clk)
    begin
        if (state == FETCH_DECODE && dec_opcode != OP_END)
        begin
            cmd_opcode    <= dec_opcode;
            launch_opcode <= dec_opcode;
            launch_base   <= {next_word, 2'b00};
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_done_in_wait : assert property (
        @(posedge clk) disable iff (!reset)
        burst_done |-> (state == FETCH_WAIT)
    ) else $error("gl_fetch: burst_done while not waiting on a burst");

endmodule

// ==== rtl/gl_operand_reader.sv ====
`timescale 1ns/1ps

module gl_operand_reader (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 launch,
    input  gl_pkg::opcode_t      launch_opcode,
    input  gl_pkg::byte_addr_t   launch_base,
    output gl_pkg::byte_addr_t   operand_addr,
    input  gl_pkg::word_t        operand_rdata,
    output logic                 operand_valid,
    output gl_pkg::opcode_t      operand_opcode,
    output gl_pkg::operand_idx_t operand_index,
    output gl_pkg::word_t        operand_data,
    output logic                 burst_done
);
    import gl_pkg::*;

    localparam int ADDR_W = $bits(byte_addr_t);

    reader_state_t state;

    // Issue side
    logic [ADDR_W-3:0] addr_word;
    operand_idx_t      issue_idx;
    operand_idx_t      burst_len;
    opcode_t           burst_opcode;
    logic              issue_last;

    // Stage tracking the memory read latency
    logic              s1_valid;
    operand_idx_t      s1_idx;
    logic              s1_last;

    assign operand_addr = {addr_word, 2'b00};
    assign issue_last   = (issue_idx == burst_len - 5'd1);

    ////////////////////
    // Address issue
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= READ_IDLE;
        else if (state == READ_IDLE && launch)
            state <= READ_BURST;
        else if (state == READ_BURST && issue_last)
            state <= READ_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (state == READ_IDLE && launch)
        begin
            addr_word    <= launch_base[ADDR_W-1:2];
            issue_idx    <= '0;
            burst_len    <= operand_count(launch_opcode);
            burst_opcode <= launch_opcode;
        end
        else if (state == READ_BURST)
        begin
            addr_word <= addr_word + 1'b1;
            issue_idx <= issue_idx + 5'd1;
        end
    end

    ////////////////////
    // Return pipeline
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            s1_valid      <= 1'b0;
            operand_valid <= 1'b0;
            burst_done    <= 1'b0;
        end
        else
        begin
            s1_valid      <= (state == READ_BURST);
            operand_valid <= s1_valid;
            burst_done    <= s1_valid && s1_last;
        end
    end

    // Index rides along with the address, data joins one edge later
    always_ff @(posedge clk)
    begin
        s1_idx         <= issue_idx;
        s1_last        <= issue_last;
        operand_index  <= s1_idx;
        operand_data   <= operand_rdata;
        operand_opcode <= burst_opcode;
    end

    // Fetch must wait for the previous burst to drain fully
    a_launch_when_idle : assert property (
        @(posedge clk) disable iff (!reset)
        launch |-> (state == READ_IDLE) && !s1_valid && !operand_valid
                   && (operand_count(launch_opcode) != 5'd0)
    ) else $error("gl_operand_reader: launch while a burst is running");

endmodule

// ==== rtl/gl_cmd_proc.sv ====
`timescale 1ns/1ps

module gl_cmd_proc (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 hold,
    input  logic                 load_en,
    input  gl_pkg::byte_addr_t   load_addr,
    input  gl_pkg::word_t        load_data,
    output logic                 cmd_valid,
    output gl_pkg::opcode_t      cmd_opcode,
    output logic                 operand_valid,
    output gl_pkg::opcode_t      operand_opcode,
    output gl_pkg::operand_idx_t operand_index,
    output gl_pkg::word_t        operand_data,
    output logic                 done
);
    import gl_pkg::*;

    // Memory read ports
    byte_addr_t inst_addr;
    word_t      inst_data;
    byte_addr_t operand_addr;
    word_t      operand_rdata;

    // Fetch to reader handoff
    logic       launch;
    opcode_t    launch_opcode;
    byte_addr_t launch_base;
    logic       burst_done;

    gl_cmd_mem gl_cmd_mem_inst (
        .clk           (clk),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .inst_addr     (inst_addr),
        .inst_data     (inst_data),
        .operand_addr  (operand_addr),
        .operand_rdata (operand_rdata)
    );

    gl_fetch gl_fetch_inst (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .hold          (hold),
        .inst_addr     (inst_addr),
        .inst_data     (inst_data),
        .cmd_valid     (cmd_valid),
        .cmd_opcode    (cmd_opcode),
        .launch        (launch),
        .launch_opcode (launch_opcode),
        .launch_base   (launch_base),
        .burst_done    (burst_done),
        .done          (done)
    );

    gl_operand_reader gl_operand_reader_inst (
        .clk            (clk),
        .reset          (reset),
        .launch         (launch),
        .launch_opcode  (launch_opcode),
        .launch_base    (launch_base),
        .operand_addr   (operand_addr),
        .operand_rdata  (operand_rdata),
        .operand_valid  (operand_valid),
        .operand_opcode (operand_opcode),
        .operand_index  (operand_index),
        .operand_data   (operand_data),
        .burst_done     (burst_done)
    );

endmodule

// ==== sim/gl_cmd_proc_tb.sv ====
`timescale 1ns/1ps
`include "gl_cfg.svh"

module gl_cmd_proc_tb;
    import gl_pkg::*;

    typedef struct packed {
        opcode_t      op;
        operand_idx_t idx;
        word_t        data;
    } operand_rec_t;

    // Opcode outside the table, used when a long command no longer fits
    localparam opcode_t FILLER_OP = 8'hE5;

    logic         clk;
    logic         reset;
    logic         start;
    logic         hold;
    logic         load_en;
    byte_addr_t   load_addr;
    word_t        load_data;
    logic         cmd_valid;
    opcode_t      cmd_opcode;
    logic         operand_valid;
    opcode_t      operand_opcode;
    operand_idx_t operand_index;
    word_t        operand_data;
    logic         done;

    // Reference model
    word_t        program_words[$];
    opcode_t      exp_cmds[$];
    operand_rec_t exp_ops[$];

    int value_errors;
    int other_errors;
    int cmds_seen;
    int cycle_count;
    int limit_cycles;
    bit limit_ready;

    // Monitor state
    int outstanding;
    int since_cmd;
    bit ops_started;
    bit hold_d1;
    bit hold_d2;
    bit reset_applied;
    bit started;
    bit done_seen;

    gl_cmd_proc gl_cmd_proc_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .hold           (hold),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .cmd_valid      (cmd_valid),
        .cmd_opcode     (cmd_opcode),
        .operand_valid  (operand_valid),
        .operand_opcode (operand_opcode),
        .operand_index  (operand_index),
        .operand_data   (operand_data),
        .done           (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Program model
    ////////////////////

    // Operand words per opcode, straight from the command table
    function automatic int operands_of(input opcode_t op);
        case (op)
            OP_VERTEX, OP_COLOR:
                return 3;
            OP_MULTMATRIX, OP_LOADMATRIX, OP_ROTATE, OP_SCALE, OP_TRANSLATE:
                return 16;
            OP_VIEWPORT:
                return 4;
            OP_FRUSTUM:
                return 6;
            default:
                return 0;
        endcase
    endfunction

    // Roughly one in eight unknown, matrix commands kept rarer to fit memory
    function automatic opcode_t pick_opcode();
        int      kind;
        opcode_t op;
        kind = $urandom_range(0, 7);
        if (kind == 0)
        begin
            do
                op = opcode_t'($urandom_range(1, 255));
            while (operands_of(op) != 0);
            return op;
        end
        if ($urandom_range(0, 3) == 0)
        begin
            case ($urandom_range(0, 4))
                0: return OP_MULTMATRIX;
                1: return OP_LOADMATRIX;
                2: return OP_ROTATE;
                3: return OP_SCALE;
                default: return OP_TRANSLATE;
            endcase
        end
        case ($urandom_range(0, 3))
            0: return OP_VERTEX;
            1: return OP_COLOR;
            2: return OP_VIEWPORT;
            default: return OP_FRUSTUM;
        endcase
    endfunction

    task automatic add_command(input opcode_t op);
        word_t        w;
        operand_rec_t rec;
        int           n;
        n = operands_of(op);
        w = $urandom;
        w[7:0] = op;
        program_words.push_back(w);
        exp_cmds.push_back(op);
        for (int i = 0; i < n; i++)
        begin
            rec.op   = op;
            rec.idx  = operand_idx_t'(i);
            rec.data = $urandom;
            program_words.push_back(rec.data);
            exp_ops.push_back(rec);
        end
    endtask

    task automatic build_program();
        int      ncmd;
        int      made;
        word_t   w;
        opcode_t op;
        ncmd = $urandom_range(20, 30);
        made = 0;
        while (made < ncmd)
        begin
            op = pick_opcode();
            // One word always stays free for END
            if (program_words.size() + operands_of(op) + 2 > `GL_MEM_WORDS)
                op = FILLER_OP;
            if (program_words.size() + 2 > `GL_MEM_WORDS)
                break;
            add_command(op);
            made++;
        end
        // Upper bits of the END word are noise on purpose
        w = $urandom;
        w[7:0] = OP_END;
        program_words.push_back(w);
        limit_cycles = 8 * program_words.size() + 200;
        limit_ready  = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < program_words.size(); i++)
        begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = byte_addr_t'(`GL_TEXT_START + 4 * i);
            load_data = program_words[i];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    ////////////////////
    // Checking
    ////////////////////

    always @(posedge clk)
    begin
        operand_rec_t rec;
        opcode_t      exp_op;

        // Outputs are defined from the second reset edge on
        if (reset_applied && !started)
        begin
            assert (cmd_valid === 1'b0 && operand_valid === 1'b0 && done === 1'b0)
            else
            begin
                other_errors++;
                $display("Strobe or done active during reset or before start");
            end
        end
        if (reset === 1'b0)
            reset_applied = 1'b1;
        if (start === 1'b1)
            started = 1'b1;

        // A command seen now left ISSUE two edges back
        assert (!(cmd_valid === 1'b1 && hold_d2))
        else
        begin
            other_errors++;
            $display("New command issued while hold was raised");
        end
        hold_d2 = hold_d1;
        hold_d1 = (hold === 1'b1);

        if (done_seen)
        begin
            assert (done === 1'b1)
            else
            begin
                other_errors++;
                $display("done dropped after the end of the stream");
            end
            assert (cmd_valid !== 1'b1 && operand_valid !== 1'b1)
            else
            begin
                other_errors++;
                $display("Strobe seen after the end of the stream");
            end
        end
        else if (done === 1'b1)
        begin
            done_seen = 1'b1;
            assert (exp_cmds.size() == 0 && exp_ops.size() == 0 && outstanding == 0)
            else
            begin
                other_errors++;
                $display("done raised with %0d commands and %0d operands still expected",
                         exp_cmds.size(), exp_ops.size());
            end
        end

        if (outstanding > 0 && !ops_started)
            since_cmd++;

        if (cmd_valid === 1'b1)
        begin
            cmds_seen++;
            assert (outstanding == 0)
            else
            begin
                other_errors++;
                $display("Command %h arrived with %0d operands of the previous one outstanding",
                         cmd_opcode, outstanding);
            end
            assert (exp_cmds.size() > 0)
            else
            begin
                other_errors++;
                $display("Command %h arrived after the last expected command", cmd_opcode);
            end
            if (exp_cmds.size() > 0)
            begin
                exp_op = exp_cmds.pop_front();
                assert (cmd_opcode === exp_op)
                else
                begin
                    value_errors++;
                    $display("ERR command_sequence: expected %h, actual %h", exp_op, cmd_opcode);
                end
                outstanding = operands_of(exp_op);
            end
            since_cmd   = 0;
            ops_started = 1'b0;
        end

        if (operand_valid === 1'b1)
        begin
            assert (exp_ops.size() > 0 && outstanding > 0)
            else
            begin
                other_errors++;
                $display("Operand strobe with no operand expected");
            end
            if (exp_ops.size() > 0)
            begin
                rec = exp_ops.pop_front();
                assert (operand_opcode === rec.op)
                else
                begin
                    value_errors++;
                    $display("ERR operand_opcode: expected %h, actual %h", rec.op, operand_opcode);
                end
                assert (operand_index === rec.idx)
                else
                begin
                    value_errors++;
                    $display("ERR operand_index: expected %0d, actual %0d",
                             rec.idx, operand_index);
                end
                assert (operand_data === rec.data)
                else
                begin
                    value_errors++;
                    $display("ERR operand_data: expected %h, actual %h", rec.data, operand_data);
                end
            end
            // First strobe two edges after the reader samples launch
            if (!ops_started)
            begin
                assert (since_cmd == 3)
                else
                begin
                    value_errors++;
                    $display("ERR operand_latency: expected 3, actual %0d", since_cmd);
                end
            end
            ops_started = 1'b1;
            if (outstanding > 0)
                outstanding--;
        end
        else if (outstanding > 0)
        begin
            assert (!ops_started)
            else
            begin
                other_errors++;
                $display("Gap in operand burst with %0d operands outstanding", outstanding);
            end
            assert (since_cmd < 3)
            else
            begin
                other_errors++;
                $display("Operand burst did not start in time");
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial
    begin
        int hold_after;
        int hold_len;

        reset     = 1'b0;
        start     = 1'b0;
        hold      = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;

        value_errors  = 0;
        other_errors  = 0;
        cmds_seen     = 0;
        cycle_count   = 0;
        outstanding   = 0;
        since_cmd     = 0;
        ops_started   = 1'b0;
        hold_d1       = 1'b0;
        hold_d2       = 1'b0;
        reset_applied = 1'b0;
        started       = 1'b0;
        done_seen     = 1'b0;
        limit_ready   = 1'b0;

        void'($urandom(32'h4b35_e694));
        build_program();
        hold_after = $urandom_range(4, 10);
        hold_len   = $urandom_range(20, 60);

        repeat (2) @(negedge clk);
        reset = 1'b1;

        load_program();
        repeat (3) @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 0;

        // Stall the stream for a while somewhere mid program
        while (cmds_seen < hold_after && done !== 1'b1)
            @(negedge clk);
        hold = 1'b1;
        repeat (hold_len) @(negedge clk);
        hold = 1'b0;

        while (done !== 1'b1)
            @(negedge clk);
        // Quiet window, nothing may follow END
        repeat (20) @(negedge clk);

        assert (exp_cmds.size() == 0 && exp_ops.size() == 0 && done === 1'b1)
        else
        begin
            other_errors++;
            $display("Run ended with %0d commands and %0d operands never seen",
                     exp_cmds.size(), exp_ops.size());
        end

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // Cycle budget scales with the program length
    initial
    begin
        wait (limit_ready);
        while (cycle_count < limit_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, end of stream was never reached", cycle_count);
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/gl_pkg.sv
rtl/gl_cmd_mem.sv
rtl/gl_fetch.sv
rtl/gl_operand_reader.sv
rtl/gl_cmd_proc.sv
sim/gl_cmd_proc_tb.sv

// ==== Bender.yml ====
package:
  name: gl_cmd_proc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/gl_pkg.sv
      - rtl/gl_cmd_mem.sv
      - rtl/gl_fetch.sv
      - rtl/gl_operand_reader.sv
      - rtl/gl_cmd_proc.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/gl_cmd_proc_tb.sv
